// File: Bender.yml
package:
  name: blob_tracker

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/tracker_pkg.sv
      - rtl/video_timing.sv
      - rtl/pixel_classify.sv
      - rtl/centroid_accumulate.sv
      - rtl/centroid_divide.sv
      - rtl/crosshair_overlay.sv
      - rtl/blob_tracker_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/blob_tracker_assertions.sv
      - test/blob_tracker_tb.sv

// File: rtl/blob_tracker_top.sv
`default_nettype none

module blob_tracker_top (
    input  wire                       clk_pixel,
    input  wire                       recent_reset,
    input  tracker_pkg::rgb_t         pixel_in,
    input  tracker_pkg::threshold_t   threshold,
    output tracker_pkg::raster_pos_t  pos_out,
    output tracker_pkg::rgb_t         pixel_out,
    output tracker_pkg::raster_pos_t  video_out_pos,
    output tracker_pkg::centre_t      centre,
    output logic                      centre_valid
);

    import tracker_pkg::*;

    // decode stage output, shared by accumulate and overlay
    tagged_pixel_t classified;

    // handshake between accumulator and divider
    logic        div_req;
    logic        div_ack;
    frame_sums_t sums;

    // raster position goes out to the camera side as well
    video_timing timing_inst (
        .clk_pixel(clk_pixel),
        .recent_reset(recent_reset),
        .raster_pos(pos_out)
    );

    pixel_classify classify_inst (
        .clk_pixel(clk_pixel),
        .recent_reset(recent_reset),
        .raster_pos(pos_out),
        .pixel_in(pixel_in),
        .threshold(threshold),
        .classified(classified)
    );

    centroid_accumulate accumulate_inst (
        .clk_pixel(clk_pixel),
        .recent_reset(recent_reset),
        .classified(classified),
        .div_req(div_req),
        .sums(sums),
        .div_ack(div_ack)
    );

    centroid_divide divide_inst (
        .clk_pixel(clk_pixel),
        .recent_reset(recent_reset),
        .div_req(div_req),
        .sums(sums),
        .div_ack(div_ack),
        .centre(centre),
        .centre_valid(centre_valid)
    );

    // overlay reads the held centre straight from the divider
    crosshair_overlay overlay_inst (
        .clk_pixel(clk_pixel),
        .recent_reset(recent_reset),
        .classified(classified),
        .centre(centre),
        .centre_valid(centre_valid),
        .pixel_out(pixel_out),
        .video_out_pos(video_out_pos)
    );

endmodule

`default_nettype wire

// File: rtl/centroid_accumulate.sv
`default_nettype none

module centroid_accumulate (
    input  wire                         clk_pixel,
    input  wire                         recent_reset,
    input  tracker_pkg::tagged_pixel_t  classified,
    output logic                        div_req,
    output tracker_pkg::frame_sums_t    sums,
    input  wire                         div_ack
);

    import tracker_pkg::*;

    typedef enum logic [1:0] {
        acc_idle,
        acc_request,
        acc_release
    } acc_state_t;

    acc_state_t state;

    // running totals for the frame in progress
    frame_sums_t acc;
    frame_sums_t acc_next;
    frame_sums_t acc_base;

    localparam int sum_bits = $bits(acc.sum_x);

    // frame_start restarts the totals with its own pixel
    always_comb begin
        if (classified.pos.frame_start) begin
            acc_base = '0;
        end else begin
            acc_base = acc;
        end
        acc_next = acc_base;
        if (classified.mask) begin
            acc_next.sum_x = acc_base.sum_x + sum_bits'(classified.pos.hcount);
            acc_next.sum_y = acc_base.sum_y + sum_bits'(classified.pos.vcount);
            acc_next.count = acc_base.count + sum_bits'(1);
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            acc <= '0;
        end else begin
            acc <= acc_next;
        end
    end

    // requesting side of the four-phase handshake
    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            state   <= acc_idle;
            div_req <= 1'b0;
        end else begin
            case (state)
                acc_idle: begin
                    // empty frames leave the old centre alone
                    if (classified.pos.frame_end && (acc_next.count != '0)) begin
                        div_req <= 1'b1;
                        state   <= acc_request;
                    end
                end
                acc_request: begin
                    // centre written, let go of the request
                    if (div_ack) begin
                        div_req <= 1'b0;
                        state   <= acc_release;
                    end
                end
                acc_release: begin
                    // wait for the divider to close the cycle
                    if (!div_ack) begin
                        state <= acc_idle;
                    end
                end
                default: begin
                    div_req <= 1'b0;
                    state   <= acc_idle;
                end
            endcase
        end
    end

    // totals latched only when a request is about to start
    // a frame ending mid handshake is dropped here
    always_ff @(posedge clk_pixel) begin
        if ((state == acc_idle) && classified.pos.frame_end) begin
            sums <= acc_next;
        end
    end

endmodule

`default_nettype wire

// File: rtl/centroid_divide.sv
`include "tracker_defs.svh"

`default_nettype none

module centroid_divide (
    input  wire                       clk_pixel,
    input  wire                       recent_reset,
    input  wire                       div_req,
    input  tracker_pkg::frame_sums_t  sums,
    output logic                      div_ack,
    output tracker_pkg::centre_t      centre,
    output logic                      centre_valid
);

    import tracker_pkg::*;

    localparam int sum_bits  = `SUM_BITS;
    localparam int quot_bits = `QUOTIENT_BITS;
    localparam int step_bits = $clog2(sum_bits);

    typedef enum logic [1:0] {
        div_idle,
        div_x,
        div_y,
        div_acknowledge
    } div_state_t;

    div_state_t state;

    // restoring divider datapath
    logic [sum_bits-1:0]  dividend;
    logic [sum_bits-1:0]  remainder;
    logic [quot_bits-1:0] quotient;
    logic [quot_bits-1:0] quotient_x;
    logic [step_bits-1:0] step;

    logic [sum_bits:0]    partial;
    logic [sum_bits:0]    diff;
    logic                 fits;
    logic [sum_bits-1:0]  remainder_next;
    logic [quot_bits-1:0] quotient_next;
    logic                 last_step;

    // bring down the next dividend bit and try the subtract
    // count stays put while div_req is high
    always_comb begin
        partial        = {remainder, dividend[sum_bits-1]};
        diff           = partial - {1'b0, sums.count};
        fits           = (partial >= {1'b0, sums.count});
        remainder_next = fits ? diff[sum_bits-1:0] : partial[sum_bits-1:0];
        // high quotient bits are zero, only the low ones are kept
        quotient_next  = {quotient[quot_bits-2:0], fits};
        last_step      = (step == step_bits'(sum_bits - 1));
    end

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            state        <= div_idle;
            div_ack      <= 1'b0;
            centre       <= '0;
            centre_valid <= 1'b0;
        end else begin
            case (state)
                div_idle: begin
                    if (div_req) begin
                        state <= div_x;
                    end
                end
                div_x: begin
                    if (last_step) begin
                        state <= div_y;
                    end
                end
                div_y: begin
                    // both quotients land together with the ack
                    if (last_step) begin
                        centre.x     <= hcount_t'(quotient_x);
                        centre.y     <= vcount_t'(quotient_next);
                        centre_valid <= 1'b1;
                        div_ack      <= 1'b1;
                        state        <= div_acknowledge;
                    end
                end
                div_acknowledge: begin
                    // hold ack until the requester lets go
                    if (!div_req) begin
                        div_ack <= 1'b0;
                        state   <= div_idle;
                    end
                end
                default: begin
                    div_ack <= 1'b0;
                    state   <= div_idle;
                end
            endcase
        end
    end

    // one quotient bit per cycle, x pass then y pass
    always_ff @(posedge clk_pixel) begin
        case (state)
            div_idle: begin
                dividend  <= sums.sum_x;
                remainder <= '0;
                step      <= '0;
            end
            div_x: begin
                if (last_step) begin
                    quotient_x <= quotient_next;
                    // reload for the y pass
                    dividend   <= sums.sum_y;
                    remainder  <= '0;
                    step       <= '0;
                end else begin
                    dividend  <= {dividend[sum_bits-2:0], 1'b0};
                    remainder <= remainder_next;
                    step      <= step + step_bits'(1);
                end
                quotient <= quotient_next;
            end
            div_y: begin
                dividend  <= {dividend[sum_bits-2:0], 1'b0};
                remainder <= remainder_next;
                quotient  <= quotient_next;
                step      <= step + step_bits'(1);
            end
            default: begin
                step <= '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/crosshair_overlay.sv
`default_nettype none

module crosshair_overlay (
    input  wire                         clk_pixel,
    input  wire                         recent_reset,
    input  tracker_pkg::tagged_pixel_t  classified,
    input  tracker_pkg::centre_t        centre,
    input  wire                         centre_valid,
    output tracker_pkg::rgb_t           pixel_out,
    output tracker_pkg::raster_pos_t    video_out_pos
);

    logic on_column;
    logic on_line;
    logic draw_cross;

    // crosshair spans the whole visible area through the centre
    assign on_column  = (classified.pos.hcount == centre.x);
    assign on_line    = (classified.pos.vcount == centre.y);
    assign draw_cross = centre_valid && (on_column || on_line);

    // pixel path, no reset on colour data
    always_ff @(posedge clk_pixel) begin
        if (!classified.pos.active) begin
            // blanking goes out black
            pixel_out <= '0;
        end else if (draw_cross) begin
            // full white on every channel
            pixel_out <= '1;
        end else begin
            pixel_out <= classified.pixel;
        end
    end

    // position tag follows the pixel by the same cycle
    always_ff @(posedge clk_pixel) begin
        video_out_pos.hcount <= classified.pos.hcount;
        video_out_pos.vcount <= classified.pos.vcount;
        if (recent_reset) begin
            video_out_pos.active      <= 1'b0;
            video_out_pos.frame_start <= 1'b0;
            video_out_pos.frame_end   <= 1'b0;
        end else begin
            video_out_pos.active      <= classified.pos.active;
            video_out_pos.frame_start <= classified.pos.frame_start;
            video_out_pos.frame_end   <= classified.pos.frame_end;
        end
    end

endmodule

`default_nettype wire

// File: rtl/pixel_classify.sv
`default_nettype none

module pixel_classify (
    input  wire                         clk_pixel,
    input  wire                         recent_reset,
    input  tracker_pkg::raster_pos_t    raster_pos,
    input  tracker_pkg::rgb_t           pixel_in,
    input  tracker_pkg::threshold_t     threshold,
    output tracker_pkg::tagged_pixel_t  classified
);

    logic in_range;

    // red inside the inclusive window
    assign in_range = (threshold.lower <= pixel_in.red)
                      && (pixel_in.red <= threshold.upper);

    // one register stage keeps position and pixel aligned
    always_ff @(posedge clk_pixel) begin
        // coordinates and colour ride along unreset
        classified.pos.hcount <= raster_pos.hcount;
        classified.pos.vcount <= raster_pos.vcount;
        classified.pixel      <= pixel_in;
        if (recent_reset) begin
            classified.pos.active      <= 1'b0;
            classified.pos.frame_start <= 1'b0;
            classified.pos.frame_end   <= 1'b0;
            classified.mask            <= 1'b0;
        end else begin
            classified.pos.active      <= raster_pos.active;
            classified.pos.frame_start <= raster_pos.frame_start;
            classified.pos.frame_end   <= raster_pos.frame_end;
            // blanking pixels never count toward the target
            classified.mask            <= raster_pos.active && in_range;
        end
    end

endmodule

`default_nettype wire

// File: rtl/tracker_defs.svh
`ifndef TRACKER_DEFS_SVH
`define TRACKER_DEFS_SVH

`default_nettype none

// raster geometry, kept tiny so a frame simulates quickly
// visible columns per line
`define H_ACTIVE 64
// columns per line including blanking
`define H_TOTAL 80
// visible lines per frame
`define V_ACTIVE 36
// lines per frame including blanking
`define V_TOTAL 40

// bits in one colour channel
`define COLOR_BITS 8

// coordinate sums over a full frame
// 64*36 pixels with x up to 63 stays well under 2^24
`define SUM_BITS 24
// quotient width of one centre coordinate
`define QUOTIENT_BITS 8

`default_nettype wire

`endif

// File: rtl/tracker_pkg.sv
`include "tracker_defs.svh"

`default_nettype none

package tracker_pkg;

    // raster coordinates, sized for H_TOTAL and V_TOTAL
    typedef logic [6:0] hcount_t;
    typedef logic [5:0] vcount_t;

    typedef logic [`COLOR_BITS-1:0] channel_t;

    typedef struct packed {
        channel_t red;
        channel_t green;
        channel_t blue;
    } rgb_t;

    // position of the pixel on the wire plus frame markers
    typedef struct packed {
        hcount_t hcount;
        vcount_t vcount;
        // inside the visible area
        logic active;
        // first visible pixel of the frame
        logic frame_start;
        // last visible pixel of the frame
        logic frame_end;
    } raster_pos_t;

    // inclusive bounds on the red channel
    typedef struct packed {
        channel_t lower;
        channel_t upper;
    } threshold_t;

    typedef struct packed {
        raster_pos_t pos;
        rgb_t pixel;
        logic mask;
    } tagged_pixel_t;

    typedef struct packed {
        logic [`SUM_BITS-1:0] sum_x;
        logic [`SUM_BITS-1:0] sum_y;
        logic [`SUM_BITS-1:0] count;
    } frame_sums_t;

    typedef struct packed {
        hcount_t x;
        vcount_t y;
    } centre_t;

endpackage

`default_nettype wire

// File: rtl/video_timing.sv
`include "tracker_defs.svh"

`default_nettype none

module video_timing (
    input  wire                       clk_pixel,
    input  wire                       recent_reset,
    output tracker_pkg::raster_pos_t  raster_pos
);

    import tracker_pkg::*;

    hcount_t hcount;
    vcount_t vcount;

    logic line_done;
    logic frame_done;

    // wrap points of the two counters
    assign line_done  = (hcount == hcount_t'(`H_TOTAL - 1));
    assign frame_done = (vcount == vcount_t'(`V_TOTAL - 1));

    // column counter runs every cycle
    // line counter steps once per line
    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            hcount <= '0;
            vcount <= '0;
        end else begin
            if (line_done) begin
                hcount <= '0;
                if (frame_done) begin
                    vcount <= '0;
                end else begin
                    vcount <= vcount + vcount_t'(1);
                end
            end else begin
                hcount <= hcount + hcount_t'(1);
            end
        end
    end

    // flags decoded straight from the counts
    always_comb begin
        raster_pos.hcount = hcount;
        raster_pos.vcount = vcount;
        raster_pos.active = (hcount < hcount_t'(`H_ACTIVE))
                            && (vcount < vcount_t'(`V_ACTIVE));
        // top left corner of the visible area
        raster_pos.frame_start = (hcount == '0) && (vcount == '0);
        // bottom right corner of the visible area
        raster_pos.frame_end = (hcount == hcount_t'(`H_ACTIVE - 1))
                               && (vcount == vcount_t'(`V_ACTIVE - 1));
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+rtl
rtl/tracker_pkg.sv
rtl/video_timing.sv
rtl/pixel_classify.sv
rtl/centroid_accumulate.sv
rtl/centroid_divide.sv
rtl/crosshair_overlay.sv
rtl/blob_tracker_top.sv
test/blob_tracker_assertions.sv
test/blob_tracker_tb.sv

// File: test/blob_tracker_assertions.sv
`default_nettype none

module blob_tracker_assertions (
    input wire                            clk_pixel,
    input wire                            recent_reset,
    input wire                            div_req,
    input wire                            div_ack,
    input wire tracker_pkg::frame_sums_t  sums
);

    // error count, read back by the testbench
    int failures = 0;

    // requester keeps asking until it is answered
    property req_held_until_ack;
        @(posedge clk_pixel) disable iff (recent_reset)
            (div_req && !div_ack) |=> div_req;
    endproperty

    // divider reads the sums over many cycles
    property sums_stable_during_req;
        @(posedge clk_pixel) disable iff (recent_reset)
            div_req |=> (!div_req || $stable(sums));
    endproperty

    // ack stays up until the request is gone
    property ack_held_while_req;
        @(posedge clk_pixel) disable iff (recent_reset)
            (div_ack && div_req) |=> div_ack;
    endproperty

    // no answer without a question
    property ack_needs_req;
        @(posedge clk_pixel) disable iff (recent_reset)
            $rose(div_ack) |-> div_req;
    endproperty

    // both sides quiet once reset has been seen
    property idle_after_reset;
        @(posedge clk_pixel)
            recent_reset |=> (!div_req && !div_ack);
    endproperty

    req_held: assert property (req_held_until_ack)
        else begin
            $error("div_req dropped before div_ack arrived");
            failures++;
        end

    sums_held: assert property (sums_stable_during_req)
        else begin
            $error("sums changed while div_req was high");
            failures++;
        end

    ack_held: assert property (ack_held_while_req)
        else begin
            $error("div_ack dropped while div_req was still high");
            failures++;
        end

    ack_sourced: assert property (ack_needs_req)
        else begin
            $error("div_ack rose without a request");
            failures++;
        end

    reset_idle: assert property (idle_after_reset)
        else begin
            $error("handshake not idle after reset");
            failures++;
        end

endmodule

// same handshake seen from the requester and from the divider
bind centroid_accumulate blob_tracker_assertions acc_protocol (
    .clk_pixel(clk_pixel),
    .recent_reset(recent_reset),
    .div_req(div_req),
    .div_ack(div_ack),
    .sums(sums)
);

bind centroid_divide blob_tracker_assertions div_protocol (
    .clk_pixel(clk_pixel),
    .recent_reset(recent_reset),
    .div_req(div_req),
    .div_ack(div_ack),
    .sums(sums)
);

`default_nettype wire

// File: test/blob_tracker_tb.sv
`include "tracker_defs.svh"

`default_nettype none

module blob_tracker_tb;

    import tracker_pkg::*;

    localparam int frames = 7;
    // run length plus one spare frame
    localparam int timeout_cycles = (frames + 1) * `H_TOTAL * `V_TOTAL;
    localparam channel_t red_lower = 8'h80;
    localparam channel_t red_upper = 8'he0;
    // this frame carries no target
    localparam int blank_frame = 3;

    logic        clk_pixel = 1'b0;
    logic        recent_reset;
    rgb_t        pixel_in;
    threshold_t  threshold;
    raster_pos_t pos_out;
    rgb_t        pixel_out;
    raster_pos_t video_out_pos;
    centre_t     centre;
    logic        centre_valid;

    logic [31:0] rng = 32'd89490;
    int          cycle_count = 0;
    // raster position the testbench expects next
    int          col;
    int          row;
    int          frame_count;
    // target rectangle of the current frame
    int          rect_x0;
    int          rect_x1;
    int          rect_y0;
    int          rect_y1;
    logic        has_target;
    logic        in_rect;
    // reference sums over masked pixels
    int          sum_x;
    int          sum_y;
    int          sum_count;
    centre_t     exp_centre;
    logic        exp_valid;
    // centre the overlay uses for the frame on the wire
    centre_t     draw_centre;
    logic        draw_valid;
    raster_pos_t exp_pos;
    rgb_t        drive_pixel;
    rgb_t        exp_out;
    // index 1 holds what was driven two cycles back
    raster_pos_t pos_hist [2];
    rgb_t        pixel_hist [2];
    int          hist_fill;

    blob_tracker_top DUT (
        .clk_pixel(clk_pixel),
        .recent_reset(recent_reset),
        .pixel_in(pixel_in),
        .threshold(threshold),
        .pos_out(pos_out),
        .pixel_out(pixel_out),
        .video_out_pos(video_out_pos),
        .centre(centre),
        .centre_valid(centre_valid)
    );

    always #50 clk_pixel = ~clk_pixel;

    function automatic logic [31:0] next_random(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // flags straight from the raster rules
    function automatic raster_pos_t expected_pos(input int h, input int v);
        raster_pos_t p;
        p.hcount      = hcount_t'(h);
        p.vcount      = vcount_t'(v);
        p.active      = (h < `H_ACTIVE) && (v < `V_ACTIVE);
        p.frame_start = (h == 0) && (v == 0);
        p.frame_end   = (h == `H_ACTIVE - 1) && (v == `V_ACTIVE - 1);
        return p;
    endfunction

    function automatic int handshake_errors();
        return DUT.accumulate_inst.acc_protocol.failures
               + DUT.divide_inst.div_protocol.failures;
    endfunction

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
            abort_run();
        end
    endtask

    always @(posedge clk_pixel) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("run did not finish within %0d cycles", timeout_cycles);
            abort_run();
        end
    end

    initial begin
        recent_reset    = 1'b1;
        pixel_in        = '0;
        threshold.lower = red_lower;
        threshold.upper = red_upper;
        col             = 0;
        row             = 0;
        frame_count     = 0;
        has_target      = 1'b0;
        sum_x           = 0;
        sum_y           = 0;
        sum_count       = 0;
        exp_centre      = '0;
        exp_valid       = 1'b0;
        draw_centre     = '0;
        draw_valid      = 1'b0;
        hist_fill       = 0;
        repeat (3) @(posedge clk_pixel);
        #10;
        recent_reset = 1'b0;
        forever begin
            // two cycle path through classify and overlay
            if (hist_fill >= 2) begin
                exp_out = pixel_hist[1];
                if (!pos_hist[1].active) begin
                    exp_out = '0;
                end else if (draw_valid && ((pos_hist[1].hcount == draw_centre.x)
                             || (pos_hist[1].vcount == draw_centre.y))) begin
                    exp_out = '1;
                end
                check_value("video_out_pos", pos_hist[1], video_out_pos);
                check_value("pixel_out", exp_out, pixel_out);
            end
            assert (handshake_errors() == 0) else begin
                $display("handshake protocol assertion failed");
                abort_run();
            end
            exp_pos = expected_pos(col, row);
            check_value("pos_out", exp_pos, pos_out);
            if (exp_pos.frame_start) begin
                // previous frame result must be in place by now
                check_value($sformatf("centre.x at frame %0d", frame_count),
                            exp_centre.x, centre.x);
                check_value($sformatf("centre.y at frame %0d", frame_count),
                            exp_centre.y, centre.y);
                check_value($sformatf("centre_valid at frame %0d", frame_count),
                            exp_valid, centre_valid);
                draw_centre = exp_centre;
                draw_valid  = exp_valid;
                if (frame_count == frames) begin
                    break;
                end
                rng     = next_random(rng);
                rect_x0 = rng % 52;
                rect_x1 = rect_x0 + 2 + (rng >> 8) % 10;
                rect_y0 = (rng >> 16) % 28;
                rect_y1 = rect_y0 + 1 + (rng >> 24) % 7;
                has_target = (frame_count != blank_frame);
                sum_x      = 0;
                sum_y      = 0;
                sum_count  = 0;
                frame_count++;
            end
            rng = next_random(rng);
            drive_pixel.green = rng[7:0];
            drive_pixel.blue  = rng[15:8];
            in_rect = has_target && (col >= rect_x0) && (col <= rect_x1)
                      && (row >= rect_y0) && (row <= rect_y1);
            if (!exp_pos.active) begin
                // blanking carries junk that must not count
                drive_pixel.red = rng[31:24];
            end else if (in_rect) begin
                drive_pixel.red = channel_t'(int'(red_lower)
                                  + int'(rng[23:16]) % (red_upper - red_lower + 1));
            end else begin
                drive_pixel.red = '0;
            end
            pixel_in = drive_pixel;
            // reference sums from the threshold rule
            if (exp_pos.active && (drive_pixel.red >= red_lower)
                && (drive_pixel.red <= red_upper)) begin
                sum_x     = sum_x + col;
                sum_y     = sum_y + row;
                sum_count = sum_count + 1;
            end
            // an empty frame keeps the old centre
            if (exp_pos.frame_end && (sum_count != 0)) begin
                exp_centre.x = hcount_t'(sum_x / sum_count);
                exp_centre.y = vcount_t'(sum_y / sum_count);
                exp_valid    = 1'b1;
            end
            pos_hist[1]   = pos_hist[0];
            pixel_hist[1] = pixel_hist[0];
            pos_hist[0]   = exp_pos;
            pixel_hist[0] = drive_pixel;
            if (hist_fill < 2) begin
                hist_fill++;
            end
            col++;
            if (col == `H_TOTAL) begin
                col = 0;
                row++;
                if (row == `V_TOTAL) begin
                    row = 0;
                end
            end
            @(posedge clk_pixel);
            #10;
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire
